// File: verification/spectrum_input.txt
// columns: op a b c, all hex
// op 1 write reg a with b; 2 read reg a, expect data b and pslverr c
// op 3 frame of a words, word i = b + i*c; 4 frame of a random words
// op 5 check the displayed frame; 6 end of test a; 0 end of file
2 0 0 0
2 4 0 0
2 8 0 0
2 C 0 0
5 0 0 0
1 4 00FF8000 0
1 8 00102030 0
1 0 00000015 0
2 0 00000015 0
2 4 00FF8000 0
2 8 00102030 0
1 6 FFFFFFFF 0
2 6 0 1
1 C 00001234 0
2 C 0 0
6 1 0 0
1 0 00000001 0
3 40 0 1
5 0 0 0
1 0 0000000D 0
3 40 10 40
5 0 0 0
6 2 0 0
1 0 00000007 0
3 40 FFF0FFF0 FFFC0000
5 0 0 0
1 0 0000002B 0
4 40 0 0
5 0 0 0
6 3 0 0
1 0 00000001 0
3 10 5 0
5 0 0 0
3 50 0 1
5 0 0 0
3 8 2A 0
5 0 0 0
6 4 0 0
2 C 7 0
1 0 0 0
3 40 3F 0
5 0 0 0
2 C 8 0
6 5 0 0
0 0 0 0

// File: spectrum_display_top.f
verilog/spectrum_pkg.sv
verilog/spectrum_ifs.sv
verilog/fft_bin_capture.sv
verilog/bin_height_ram.sv
verilog/video_timing_gen.sv
verilog/bar_renderer.sv
verilog/spectrum_ctrl.sv
verilog/spectrum_display_top.sv
verification/spectrum_checker.sv
verification/spectrum_display_props.sv
verification/tb_spectrum_display.sv

// File: Bender.yml
package:
  name: spectrum_display

sources:
  - verilog/spectrum_pkg.sv
  - verilog/spectrum_ifs.sv
  - verilog/fft_bin_capture.sv
  - verilog/bin_height_ram.sv
  - verilog/video_timing_gen.sv
  - verilog/bar_renderer.sv
  - verilog/spectrum_ctrl.sv
  - verilog/spectrum_display_top.sv
  - target: simulation
    files:
      - verification/spectrum_checker.sv
      - verification/spectrum_display_props.sv
      - verification/tb_spectrum_display.sv

// File: verification/tb_spectrum_display.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spectrum_display;

   localparam int vs_timeout    = 2 * spectrum_pkg::h_total * spectrum_pkg::v_total;
   localparam int frame_timeout = 3 * spectrum_pkg::h_total * spectrum_pkg::v_total;

   logic        sys_clk;
   logic        rst_n;
   logic [3:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [31:0] fft_data;
   logic        fft_valid;
   logic        fft_eop;
   logic        vs_out;
   logic        hs_out;
   logic        de_out;
   logic [7:0]  r_out;
   logic [7:0]  g_out;
   logic [7:0]  b_out;

   logic [31:0] script [0:255];             // records of op, a, b, c
   logic [5:0]  model [2][64];              // expected contents of both banks
   logic        wb;                         // bank being written
   logic [5:0]  ctrl_m;
   logic [23:0] bar_m;
   logic [23:0] bg_m;
   logic [63:0][5:0] exp_height;
   logic        check_req;
   logic        chk_done;
   logic        aborted;                    // a wait ran out or the script was bad
   int          chk_errs;
   int          seed;
   int          tb_errs;
   int          nchecks;
   int          ntests;
   int          test_base;

   spectrum_display_top spectrum_display_top_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .fft_data  (fft_data),
      .fft_valid (fft_valid),
      .fft_eop   (fft_eop),
      .vs_out    (vs_out),
      .hs_out    (hs_out),
      .de_out    (de_out),
      .r_out     (r_out),
      .g_out     (g_out),
      .b_out     (b_out)
   );

   spectrum_checker spectrum_checker_inst (
      .sys_clk    (sys_clk),
      .de_out     (de_out),
      .vs_out     (vs_out),
      .r_out      (r_out),
      .g_out      (g_out),
      .b_out      (b_out),
      .check_req  (check_req),
      .exp_height (exp_height),
      .bar_color  (bar_m),
      .bg_color   (bg_m),
      .enable     (ctrl_m[0]),
      .check_done (chk_done),
      .err_cnt    (chk_errs)
   );

   always #5 sys_clk = ~sys_clk;

   function automatic int total_errors();
      return tb_errs + chk_errs +
             spectrum_display_top_inst.spectrum_display_props_inst.assert_fails;
   endfunction

   // bar height of one FFT word under the current ctrl setting
   function automatic logic [5:0] height_of(input logic [31:0] w);
      int     re;
      int     im;
      longint m;
      re = $signed(w[31:16]);
      im = $signed(w[15:0]);
      if (ctrl_m[1])
         m = (re < 0 ? -re : re) + (im < 0 ? -im : im);  // |re| + |im|
      else
         m = w;
      m = m >> ctrl_m[5:2];
      return (m > 63) ? 6'd63 : m[5:0];
   endfunction

   task automatic report_abort(input string why);
      $display("%s", why);
      aborted = 1'b1;
   endtask

   ////////////////////////////////////////////////////
   // APB and video waits
   ////////////////////////////////////////////////////
   task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      int t;
      @(posedge sys_clk);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= data;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge sys_clk);
      penable <= 1'b1;                      // access phase
      t = 0;
      do begin
         @(posedge sys_clk);
         t++;
      end while (!pready && t < 16);
      if (!pready)
         report_abort("APB transfer never saw pready");
      rdata = prdata;
      err   = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic wait_vs_rise(input int n);
      int t;
      for (int k = 0; k < n; k++) begin
         t = 0;
         while (vs_out && t < vs_timeout) begin
            @(posedge sys_clk);
            t++;
         end
         while (!vs_out && t < vs_timeout) begin
            @(posedge sys_clk);
            t++;
         end
         if (t >= vs_timeout) begin
            report_abort("timeout while waiting for vs_out");
            return;
         end
      end
   endtask

   ////////////////////////////////////////////////////
   // FFT frames and display checks
   ////////////////////////////////////////////////////
   task automatic send_frame(input int count, input logic [31:0] start,
                             input logic [31:0] step, input logic rnd);
      logic [31:0] w;
      for (int i = 0; i < count; i++) begin
         if (rnd || i >= spectrum_pkg::num_bins)
            w = $random(seed);              // filler beyond bin 63 is dropped
         else
            w = start + i * step;
         if (i < spectrum_pkg::num_bins)
            model[wb][i] = height_of(w);
         @(posedge sys_clk);
         fft_data  <= w;
         fft_valid <= 1'b1;
         fft_eop   <= (i == count - 1);
      end
      @(posedge sys_clk);
      fft_valid <= 1'b0;
      fft_eop   <= 1'b0;
      wb = !wb;                             // swapped in at the next vs
      wait_vs_rise(2);
   endtask

   task automatic check_frame();
      int t;
      for (int i = 0; i < spectrum_pkg::num_bins; i++)
         exp_height[i] <= model[!wb][i];
      @(posedge sys_clk);
      check_req <= 1'b1;
      @(posedge sys_clk);
      check_req <= 1'b0;
      t = 0;
      do begin
         @(posedge sys_clk);
         t++;
      end while (!chk_done && t < frame_timeout);
      if (!chk_done) begin
         report_abort("timeout while waiting for the checked frame");
         return;
      end
      nchecks++;
   endtask

   initial begin
      int          pc;
      int          errs;
      logic [31:0] op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] rdata;
      logic        err;
      logic        exp_err;
      sys_clk    = 1'b0;
      rst_n      = 1'b0;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      fft_data   = '0;
      fft_valid  = 1'b0;
      fft_eop    = 1'b0;
      check_req  = 1'b0;
      exp_height = '0;
      ctrl_m     = '0;
      bar_m      = '0;
      bg_m       = '0;
      wb         = 1'b0;
      aborted    = 1'b0;
      seed       = 32'h902a;
      tb_errs    = 0;
      nchecks    = 0;
      ntests     = 0;
      test_base  = 0;
      for (int k = 0; k < 2; k++)
         for (int i = 0; i < 64; i++)
            model[k][i] = '0;
      $readmemh("verification/spectrum_input.txt", script);
      repeat (5) @(posedge sys_clk);
      rst_n <= 1'b1;
      pc = 0;
      while (!aborted && pc < 252 && script[pc] !== 32'h0) begin
         op = script[pc];
         a  = script[pc+1];
         b  = script[pc+2];
         c  = script[pc+3];
         pc += 4;
         case (op)
            32'h1: begin
               apb_xfer(a[3:0], 1'b1, b, rdata, err);
               exp_err = 1'b0;
               case (a[3:0])
                  spectrum_pkg::reg_ctrl:      ctrl_m = b[5:0];
                  spectrum_pkg::reg_bar_color: bar_m  = b[23:0];
                  spectrum_pkg::reg_bg_color:  bg_m   = b[23:0];
                  spectrum_pkg::reg_status:    ;  // read only, no error
                  default:                     exp_err = 1'b1;
               endcase
               nchecks++;
               if (err !== exp_err) begin
                  tb_errs++;
                  $display("** Error: pslverr at 0x%h: got %h, expected %h",
                           a[3:0], err, exp_err);
               end
            end
            32'h2: begin
               apb_xfer(a[3:0], 1'b0, 32'h0, rdata, err);
               nchecks++;
               if (rdata !== b) begin
                  tb_errs++;
                  $display("** Error: prdata at 0x%h: got %h, expected %h", a[3:0], rdata, b);
               end
               if (err !== c[0]) begin
                  tb_errs++;
                  $display("** Error: pslverr at 0x%h: got %h, expected %h", a[3:0], err, c[0]);
               end
            end
            32'h3: send_frame(a, b, c, 1'b0);
            32'h4: send_frame(a, 32'h0, 32'h0, 1'b1);
            32'h5: check_frame();
            32'h6: begin
               errs = total_errors();
               $display("test %0d finished with %0d errors", a, errs - test_base);
               test_base = errs;
               ntests++;
            end
            default: report_abort("unknown record in the input file");
         endcase
      end
      errs = total_errors();
      $display("%0d tests, %0d checks, %0d errors", ntests, nchecks, errs);
      if (errs == 0 && !aborted)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/spectrum_display_props.sv
`timescale 1ns/10ps
`default_nettype none

module spectrum_display_props (
   input logic sys_clk,
   input logic rst_n,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic hs_out,
   input logic vs_out,
   input logic de_out
);

   int assert_fails = 0;  // failures seen so far

   pready_in_access: assert property (@(posedge sys_clk) disable iff (!rst_n)
      psel && penable |-> pready)
      else begin
         assert_fails++;
         $error("pready low during an APB access phase");
      end

   hs_outside_de: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(hs_out && de_out))
      else begin
         assert_fails++;
         $error("hs_out and de_out high together");
      end

   vs_outside_de: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(vs_out && de_out))
      else begin
         assert_fails++;
         $error("vs_out and de_out high together");
      end

endmodule

bind spectrum_display_top spectrum_display_props spectrum_display_props_inst (
   .sys_clk (sys_clk),
   .rst_n   (rst_n),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .hs_out  (hs_out),
   .vs_out  (vs_out),
   .de_out  (de_out)
);

`default_nettype wire

// File: verification/spectrum_checker.sv
`timescale 1ns/10ps
`default_nettype none

module spectrum_checker (
   input  logic             sys_clk,
   input  logic             de_out,
   input  logic             vs_out,
   input  logic [7:0]       r_out,
   input  logic [7:0]       g_out,
   input  logic [7:0]       b_out,
   input  logic             check_req,
   input  logic [63:0][5:0] exp_height,
   input  logic [23:0]      bar_color,
   input  logic [23:0]      bg_color,
   input  logic             enable,
   output logic             check_done,
   output int               err_cnt
);

   logic        busy;
   logic        seen_vs;   // next de is line 0
   int          col;
   int          row;
   int          shown;
   logic [23:0] exp_rgb;

   // lit when the row, counted from the bottom, is below the bar height
   function automatic logic [23:0] expected_pixel(input int x, input int y);
      int h;
      h = exp_height[x / spectrum_pkg::px_per_bin];
      if (!enable)
         return 24'h000000;
      if (spectrum_pkg::height_max - y < h)
         return bar_color;
      return bg_color;
   endfunction

   initial begin
      busy       = 1'b0;
      seen_vs    = 1'b0;
      check_done = 1'b0;
      err_cnt    = 0;
      col        = 0;
      row        = 0;
      shown      = 0;
   end

   always @(posedge sys_clk) begin
      check_done <= 1'b0;
      if (!busy) begin
         if (check_req) begin
            busy    <= 1'b1;
            seen_vs <= 1'b0;
            col     <= 0;
            row     <= 0;
            shown   <= 0;
         end
      end else if (!seen_vs) begin
         seen_vs <= vs_out;
      end else if (de_out) begin
         exp_rgb = expected_pixel(col, row);
         if ({r_out, g_out, b_out} !== exp_rgb) begin
            err_cnt <= err_cnt + 1;
            shown   <= shown + 1;
            if (shown < 16)  // keep the log short on a bad frame
               $display("** Error: {r_out,g_out,b_out} at x=%0d y=%0d: got %h, expected %h",
                        col, row, {r_out, g_out, b_out}, exp_rgb);
         end
         if (col == spectrum_pkg::h_active - 1) begin
            col <= 0;
            if (row == spectrum_pkg::v_active - 1) begin
               busy       <= 1'b0;
               check_done <= 1'b1;
            end else begin
               row <= row + 1;
            end
         end else begin
            col <= col + 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/spectrum_display_top.sv
`timescale 1ns/10ps
`default_nettype none

module spectrum_display_top (
   input  logic                                sys_clk,
   input  logic                                rst_n,
   // APB slave
   input  logic [spectrum_pkg::apb_addr_w-1:0] paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   // FFT stream
   input  logic [31:0]                         fft_data,
   input  logic                                fft_valid,
   input  logic                                fft_eop,
   // video
   output logic                                vs_out,
   output logic                                hs_out,
   output logic                                de_out,
   output logic [7:0]                          r_out,
   output logic [7:0]                          g_out,
   output logic [7:0]                          b_out
);

   logic                              enable;
   logic                              complex_mode;
   logic [3:0]                        scale_shift;
   logic [23:0]                       bar_color;
   logic [23:0]                       bg_color;
   logic                              wr_bank;
   logic [spectrum_pkg::bin_w-1:0]    rd_addr;
   logic [spectrum_pkg::height_w-1:0] rd_data;
   logic                              hs;
   logic                              vs;
   logic                              de;
   logic                              vs_start;
   logic [spectrum_pkg::x_w-1:0]      x;
   logic [spectrum_pkg::y_w-1:0]      y;

   bin_wr_if bin_wr ();

   fft_bin_capture fft_bin_capture_inst (
      .sys_clk      (sys_clk),
      .rst_n        (rst_n),
      .fft_data     (fft_data),
      .fft_valid    (fft_valid),
      .fft_eop      (fft_eop),
      .complex_mode (complex_mode),
      .scale_shift  (scale_shift),
      .wr           (bin_wr.wr)
   );

   bin_height_ram bin_height_ram_inst (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .wr      (bin_wr.rd),
      .wr_bank (wr_bank),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   video_timing_gen video_timing_gen_inst (
      .sys_clk  (sys_clk),
      .rst_n    (rst_n),
      .hs       (hs),
      .vs       (vs),
      .de       (de),
      .vs_start (vs_start),
      .x        (x),
      .y        (y)
   );

   bar_renderer bar_renderer_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .x         (x),
      .y         (y),
      .de        (de),
      .hs        (hs),
      .vs        (vs),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .enable    (enable),
      .bar_color (bar_color),
      .bg_color  (bg_color),
      .vs_out    (vs_out),
      .hs_out    (hs_out),
      .de_out    (de_out),
      .r_out     (r_out),
      .g_out     (g_out),
      .b_out     (b_out)
   );

   spectrum_ctrl spectrum_ctrl_inst (
      .sys_clk      (sys_clk),
      .rst_n        (rst_n),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .frame_done   (bin_wr.frame_done),  // from capture, via the interface
      .vs_start     (vs_start),
      .enable       (enable),
      .complex_mode (complex_mode),
      .scale_shift  (scale_shift),
      .bar_color    (bar_color),
      .bg_color     (bg_color),
      .wr_bank      (wr_bank)
   );

endmodule

`default_nettype wire

// File: verilog/spectrum_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module spectrum_ctrl (
   input  logic                                sys_clk,
   input  logic                                rst_n,
   input  logic [spectrum_pkg::apb_addr_w-1:0] paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   input  logic                                frame_done,
   input  logic                                vs_start,
   output logic                                enable,
   output logic                                complex_mode,
   output logic [3:0]                          scale_shift,
   output logic [23:0]                         bar_color,
   output logic [23:0]                         bg_color,
   output logic                                wr_bank
);

   logic        access;     // APB access phase
   logic        addr_ok;
   logic        wr_strobe;
   logic [5:0]  ctrl_q;
   logic [15:0] frame_cnt;  // frames swapped in
   logic        pending;

   assign enable       = ctrl_q[spectrum_pkg::ctrl_enable_bit];
   assign complex_mode = ctrl_q[spectrum_pkg::ctrl_cplx_bit];
   assign scale_shift  = ctrl_q[spectrum_pkg::ctrl_shift_msb:spectrum_pkg::ctrl_shift_lsb];

   ////////////////////////////////////////////////////
   // APB decode, zero wait states
   ////////////////////////////////////////////////////
   assign access    = psel && penable;
   assign pready    = access;
   assign pslverr   = access && !addr_ok;
   assign wr_strobe = access && pwrite && addr_ok;

   always_comb begin
      addr_ok = 1'b1;
      prdata  = '0;
      case (paddr)
         spectrum_pkg::reg_ctrl:      prdata = 32'(ctrl_q);
         spectrum_pkg::reg_bar_color: prdata = 32'(bar_color);
         spectrum_pkg::reg_bg_color:  prdata = 32'(bg_color);
         spectrum_pkg::reg_status:    prdata = 32'(frame_cnt);
         default:                     addr_ok = 1'b0;  // read stays zero
      endcase
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q    <= '0;
         bar_color <= '0;
         bg_color  <= '0;
      end else if (wr_strobe) begin
         case (paddr)
            spectrum_pkg::reg_ctrl:      ctrl_q    <= pwdata[5:0];
            spectrum_pkg::reg_bar_color: bar_color <= pwdata[23:0];
            spectrum_pkg::reg_bg_color:  bg_color  <= pwdata[23:0];
            default:                     ;  // status is read only
         endcase
      end
   end

   ////////////////////////////////////////////////////
   // bank swap at start of vsync
   ////////////////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         pending   <= 1'b0;
         wr_bank   <= 1'b0;
         frame_cnt <= '0;
      end else if (vs_start && pending) begin
         wr_bank   <= ~wr_bank;
         frame_cnt <= frame_cnt + 16'd1;
         pending   <= frame_done;  // frame finishing right now waits for next vs
      end else if (frame_done) begin
         pending   <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/bar_renderer.sv
`timescale 1ns/10ps
`default_nettype none

module bar_renderer (
   input  logic                              sys_clk,
   input  logic                              rst_n,
   input  logic [spectrum_pkg::x_w-1:0]      x,
   input  logic [spectrum_pkg::y_w-1:0]      y,
   input  logic                              de,
   input  logic                              hs,
   input  logic                              vs,
   output logic [spectrum_pkg::bin_w-1:0]    rd_addr,
   input  logic [spectrum_pkg::height_w-1:0] rd_data,
   input  logic                              enable,
   input  logic [23:0]                       bar_color,
   input  logic [23:0]                       bg_color,
   output logic                              vs_out,
   output logic                              hs_out,
   output logic                              de_out,
   output logic [7:0]                        r_out,
   output logic [7:0]                        g_out,
   output logic [7:0]                        b_out
);

   logic [spectrum_pkg::y_w-1:0]      y_d1;
   logic                              de_d1;
   logic                              hs_d1;
   logic                              vs_d1;
   logic [spectrum_pkg::height_w-1:0] row_h;  // height of this row from the bottom
   logic                              lit;

   assign rd_addr = spectrum_pkg::bin_w'(x / spectrum_pkg::px_per_bin);
   assign row_h   = spectrum_pkg::height_w'(spectrum_pkg::height_max - y_d1);
   assign lit     = row_h < rd_data;

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         {de_d1, hs_d1, vs_d1}    <= '0;
         {de_out, hs_out, vs_out} <= '0;
         {r_out, g_out, b_out}    <= '0;
         y_d1                     <= '0;
      end else begin
         // stage one matches the memory read
         {de_d1, hs_d1, vs_d1}    <= {de, hs, vs};
         y_d1                     <= y;
         {de_out, hs_out, vs_out} <= {de_d1, hs_d1, vs_d1};
         if (!de_d1 || !enable)
            {r_out, g_out, b_out} <= 24'h000000;  // blanking or display off
         else if (lit)
            {r_out, g_out, b_out} <= bar_color;
         else
            {r_out, g_out, b_out} <= bg_color;
      end
   end

endmodule

`default_nettype wire

// File: verilog/video_timing_gen.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing_gen (
   input  logic                         sys_clk,
   input  logic                         rst_n,
   output logic                         hs,
   output logic                         vs,
   output logic                         de,
   output logic                         vs_start,
   output logic [spectrum_pkg::x_w-1:0] x,
   output logic [spectrum_pkg::y_w-1:0] y
);

   logic [7:0] h_cnt;  // 0 .. h_total-1
   logic [6:0] v_cnt;  // 0 .. v_total-1

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == spectrum_pkg::h_total - 1) begin
         h_cnt <= '0;
         if (v_cnt == spectrum_pkg::v_total - 1)
            v_cnt <= '0;
         else
            v_cnt <= v_cnt + 7'd1;
      end else begin
         h_cnt <= h_cnt + 8'd1;
      end
   end

   ////////////////////////////////////////////////////
   // registered outputs, one clock behind the counters
   ////////////////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         hs       <= 1'b0;
         vs       <= 1'b0;
         de       <= 1'b0;
         vs_start <= 1'b0;
         x        <= '0;
         y        <= '0;
      end else begin
         de <= (h_cnt < spectrum_pkg::h_active) && (v_cnt < spectrum_pkg::v_active);
         hs <= (h_cnt >= spectrum_pkg::h_sync_start) &&
               (h_cnt < spectrum_pkg::h_sync_start + spectrum_pkg::hs_len);
         vs <= (v_cnt >= spectrum_pkg::v_sync_start) &&
               (v_cnt < spectrum_pkg::v_sync_start + spectrum_pkg::vs_len);
         vs_start <= (v_cnt == spectrum_pkg::v_sync_start) && (h_cnt == 8'd0);  // lines 66/67
         x        <= h_cnt[spectrum_pkg::x_w-1:0];
         y        <= v_cnt[spectrum_pkg::y_w-1:0];
      end
   end

endmodule

`default_nettype wire

// File: verilog/bin_height_ram.sv
`timescale 1ns/10ps
`default_nettype none

module bin_height_ram (
   input  logic                              sys_clk,
   input  logic                              rst_n,
   bin_wr_if.rd                              wr,
   input  logic                              wr_bank,
   input  logic [spectrum_pkg::bin_w-1:0]    rd_addr,
   output logic [spectrum_pkg::height_w-1:0] rd_data
);

   logic [spectrum_pkg::height_w-1:0] mem [2][spectrum_pkg::num_bins];
   logic                              rd_bank;

   assign rd_bank = ~wr_bank;  // display reads the idle bank

   // both banks start as empty bars
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < spectrum_pkg::num_bins; i++) begin
               mem[b][i] <= '0;
            end
         end
      end else if (wr.wr_en) begin
         mem[wr_bank][wr.wr_addr] <= wr.wr_data;
      end
   end

   always_ff @(posedge sys_clk) begin
      rd_data <= mem[rd_bank][rd_addr];  // one clock read
   end

endmodule

`default_nettype wire

// File: verilog/fft_bin_capture.sv
`timescale 1ns/10ps
`default_nettype none

module fft_bin_capture (
   input  logic                    sys_clk,
   input  logic                    rst_n,
   input  spectrum_pkg::fft_word_u fft_data,
   input  logic                    fft_valid,
   input  logic                    fft_eop,
   input  logic                    complex_mode,
   input  logic [3:0]              scale_shift,
   bin_wr_if.wr                    wr
);

   logic [spectrum_pkg::bin_w:0]      bin_cnt;    // saturates at num_bins
   logic                              s1_valid;
   logic                              s1_eop;
   logic [spectrum_pkg::bin_w-1:0]    s1_addr;
   spectrum_pkg::fft_word_u           s1_word;
   logic                              s2_valid;
   logic                              s2_eop;
   logic [spectrum_pkg::bin_w-1:0]    s2_addr;
   logic [31:0]                       s2_mag;
   logic                              s3_eop;
   logic signed [16:0]                re_ext;
   logic signed [16:0]                im_ext;
   logic [16:0]                       abs_re;
   logic [16:0]                       abs_im;
   logic [31:0]                       mag_next;
   logic [31:0]                       shifted;

   ////////////////////////////////////////////////////
   // stage two: magnitude
   ////////////////////////////////////////////////////
   always_comb begin
      re_ext   = 17'(s1_word.cplx.re);  // sign extended
      im_ext   = 17'(s1_word.cplx.im);
      abs_re   = re_ext[16] ? -re_ext : re_ext;
      abs_im   = im_ext[16] ? -im_ext : im_ext;
      mag_next = complex_mode ? 32'(abs_re + abs_im) : s1_word.mag;
   end

   assign shifted = s2_mag >> scale_shift;

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         bin_cnt       <= '0;
         s1_valid      <= 1'b0;
         s1_eop        <= 1'b0;
         s2_valid      <= 1'b0;
         s2_eop        <= 1'b0;
         s3_eop        <= 1'b0;
         wr.wr_en      <= 1'b0;
         wr.frame_done <= 1'b0;
      end else begin
         if (fft_valid) begin
            if (fft_eop)
               bin_cnt <= '0;                      // next frame starts at bin 0
            else if (bin_cnt < spectrum_pkg::num_bins)
               bin_cnt <= bin_cnt + 1'b1;
         end
         s1_valid      <= fft_valid && (bin_cnt < spectrum_pkg::num_bins);
         s1_eop        <= fft_valid && fft_eop;    // eop ends the frame even if dropped
         s2_valid      <= s1_valid;
         s2_eop        <= s1_eop;
         wr.wr_en      <= s2_valid;
         s3_eop        <= s2_eop;
         wr.frame_done <= s3_eop;
      end
   end

   always_ff @(posedge sys_clk) begin
      s1_word    <= fft_data;
      s1_addr    <= bin_cnt[spectrum_pkg::bin_w-1:0];
      s2_mag     <= mag_next;
      s2_addr    <= s1_addr;
      wr.wr_addr <= s2_addr;
      if (shifted > spectrum_pkg::height_max)
         wr.wr_data <= spectrum_pkg::height_w'(spectrum_pkg::height_max);  // clip
      else
         wr.wr_data <= shifted[spectrum_pkg::height_w-1:0];
   end

endmodule

`default_nettype wire

// File: verilog/spectrum_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// height writes from the FFT capture into the bar memory
interface bin_wr_if;

   logic                              wr_en;
   logic [spectrum_pkg::bin_w-1:0]    wr_addr;
   logic [spectrum_pkg::height_w-1:0] wr_data;
   logic                              frame_done;  // one clock after eop write

   modport wr (
      output wr_en,
      output wr_addr,
      output wr_data,
      output frame_done
   );

   modport rd (
      input wr_en,
      input wr_addr,
      input wr_data
   );

endinterface

`default_nettype wire

// File: verilog/spectrum_pkg.sv
`default_nettype none

package spectrum_pkg;

   ////////////////////////////////////////////////////
   // raster
   ////////////////////////////////////////////////////
   localparam int h_active     = 128;  // visible columns
   localparam int h_total      = 160;  // clocks per line
   localparam int h_sync_start = 136;  // 8 clocks front porch
   localparam int hs_len       = 8;
   localparam int v_active     = 64;   // visible lines
   localparam int v_total      = 72;
   localparam int v_sync_start = 66;
   localparam int vs_len       = 2;
   localparam int x_w          = 7;
   localparam int y_w          = 6;

   ////////////////////////////////////////////////////
   // bins and bar heights
   ////////////////////////////////////////////////////
   localparam int num_bins   = 64;
   localparam int bin_w      = 6;    // bin address width
   localparam int height_w   = 6;
   localparam int height_max = 63;
   localparam int px_per_bin = 2;    // columns per bin

   ////////////////////////////////////////////////////
   // APB register map
   ////////////////////////////////////////////////////
   localparam int          apb_addr_w    = 4;
   localparam logic [3:0]  reg_ctrl      = 4'h0;
   localparam logic [3:0]  reg_bar_color = 4'h4;
   localparam logic [3:0]  reg_bg_color  = 4'h8;
   localparam logic [3:0]  reg_status    = 4'hC;

   localparam int ctrl_enable_bit = 0;
   localparam int ctrl_cplx_bit   = 1;
   localparam int ctrl_shift_lsb  = 2;
   localparam int ctrl_shift_msb  = 5;

   typedef struct packed {
      logic signed [15:0] re;  // upper half
      logic signed [15:0] im;
   } fft_cplx_s;

   // one FFT word, read as magnitude or as re/im pair
   typedef union packed {
      logic [31:0] mag;
      fft_cplx_s   cplx;
   } fft_word_u;

endpackage

`default_nettype wire
